// ==== logic/mlp_pkg.sv ====
package mlp_pkg;

	// sample, weight, bias and output width
	// two's complement throughout
	localparam int DATA_WIDTH = 16;

	// Q7.8 fixed point
	localparam int FRAC_BITS = 8;

	// accumulator width
	// 32-bit products plus headroom, sums never wrap
	localparam int ACC_WIDTH = 40;

	// leaky relu slope, negative values divided by 8
	localparam int LEAK_SHIFT = 3;

	// saturation limits of the output word
	localparam logic signed [DATA_WIDTH-1:0] DATA_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
	localparam logic signed [DATA_WIDTH-1:0] DATA_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

	// activation applied after saturation
	typedef enum logic {
		ACT_NONE,
		ACT_LEAKY_RELU
	} act_kind_e;

	// node datapath controller
	// idle waits for first input, accum for the rest,
	// output is the single result cycle
	typedef enum logic [1:0] {
		NODE_IDLE,
		NODE_ACCUM,
		NODE_OUTPUT
	} node_state_e;

endpackage

// ==== logic/feed_forward_node.sv ====
`timescale 1ns/1ps
module feed_forward_node
	import mlp_pkg::*;
	#(
		parameter int NUMBER_OF_INPUT_NODE = 2,
		parameter act_kind_e ACT_KIND = ACT_NONE
	)
	(
		input  logic                  clk,
		input  logic                  rst_n,
		input  logic                  i_load_weight_enable,
		input  logic                  i_load_data_enable,
		input  logic [DATA_WIDTH-1:0] i_weight,
		input  logic [DATA_WIDTH-1:0] i_data,
		output logic                  o_load_weight_done,
		output logic [DATA_WIDTH-1:0] o_data,
		output logic                  o_valid
	);

	// weight counter runs 0..IN, the last slot is the bias
	localparam int WCNT_W = $clog2(NUMBER_OF_INPUT_NODE + 1);
	// input counter runs 0..IN-1
	localparam int ICNT_W = (NUMBER_OF_INPUT_NODE > 1) ? $clog2(NUMBER_OF_INPUT_NODE) : 1;

	// weight and bias storage
	logic signed [DATA_WIDTH-1:0] weight_mem [NUMBER_OF_INPUT_NODE];
	logic signed [DATA_WIDTH-1:0] bias;
	logic        [WCNT_W-1:0]     wcnt;
	logic                         load_done;

	// datapath controller
	node_state_e                  state;
	logic        [ICNT_W-1:0]     in_cnt;
	logic                         in_last;

	// mac path
	logic signed [ACC_WIDTH-1:0]    acc;
	logic signed [ACC_WIDTH-1:0]    bias_wide;
	logic signed [ACC_WIDTH-1:0]    bias_ext;
	logic signed [2*DATA_WIDTH-1:0] product;
	logic signed [ACC_WIDTH-1:0]    product_wide;
	logic signed [ACC_WIDTH-1:0]    acc_base;
	logic signed [ACC_WIDTH-1:0]    acc_sum;

	// result path
	logic signed [ACC_WIDTH-1:0]  shifted;
	logic signed [DATA_WIDTH-1:0] sat;
	logic signed [DATA_WIDTH-1:0] act;

	// word accepted only until the bias has landed
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wcnt      <= '0;
			load_done <= 1'b0;
		end else if (i_load_weight_enable && !load_done) begin
			wcnt <= wcnt + 1'b1;
			if (wcnt == WCNT_W'(NUMBER_OF_INPUT_NODE)) begin
				load_done <= 1'b1;
			end
		end
	end

	// weights first, bias last
	always_ff @(posedge clk) begin
		if (i_load_weight_enable && !load_done) begin
			if (wcnt == WCNT_W'(NUMBER_OF_INPUT_NODE)) begin
				bias <= i_weight;
			end else begin
				weight_mem[wcnt[ICNT_W-1:0]] <= i_weight;
			end
		end
	end

	assign o_load_weight_done = load_done;

	// bias in the same Q format as a product
	assign bias_wide    = bias;
	assign bias_ext     = bias_wide <<< FRAC_BITS;
	assign product      = $signed(i_data) * weight_mem[in_cnt];
	assign product_wide = product;

	// first input of a sample starts from the bias
	assign acc_base = (state == NODE_IDLE) ? bias_ext : acc;
	assign acc_sum  = acc_base + product_wide;
	assign in_last  = (in_cnt == ICNT_W'(NUMBER_OF_INPUT_NODE - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= NODE_IDLE;
			in_cnt <= '0;
			acc    <= '0;
		end else begin
			case (state)
				NODE_IDLE, NODE_ACCUM: begin
					if (i_load_data_enable) begin
						acc <= acc_sum;
						if (in_last) begin
							in_cnt <= '0;
							state  <= NODE_OUTPUT;
						end else begin
							in_cnt <= in_cnt + 1'b1;
							state  <= NODE_ACCUM;
						end
					end
				end
				// single result cycle
				NODE_OUTPUT: begin
					state <= NODE_IDLE;
				end
				default: begin
					state <= NODE_IDLE;
				end
			endcase
		end
	end

	// back to Q7.8, arithmetic shift floors
	assign shifted = acc >>> FRAC_BITS;

	// clamp into 16 bits
	always_comb begin
		if (shifted > DATA_MAX) begin
			sat = DATA_MAX;
		end else if (shifted < DATA_MIN) begin
			sat = DATA_MIN;
		end else begin
			sat = shifted[DATA_WIDTH-1:0];
		end
	end

	// negative side scaled down by the leak shift
	always_comb begin
		if (ACT_KIND == ACT_LEAKY_RELU && sat[DATA_WIDTH-1]) begin
			act = sat >>> LEAK_SHIFT;
		end else begin
			act = sat;
		end
	end

	// result only during the output cycle, zero otherwise
	assign o_valid = (state == NODE_OUTPUT);
	assign o_data  = (state == NODE_OUTPUT) ? act : '0;

	// samples only once the node is fully loaded
	a_data_after_load: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_load_data_enable |-> load_done
	) else $error("node got data before weights were loaded");

endmodule

// ==== logic/feed_forward_layer.sv ====
`timescale 1ns/1ps
module feed_forward_layer
	import mlp_pkg::*;
	#(
		parameter int NUMBER_OF_INPUT_NODE = 2,
		parameter int NUMBER_OF_OUTPUT_NODE = 4,
		parameter act_kind_e ACT_KIND = ACT_NONE
	)
	(
		input  logic                             clk,
		input  logic                             rst_n,
		input  logic                             i_load_weight_enable,
		input  logic                             i_load_data_enable,
		input  logic [NUMBER_OF_OUTPUT_NODE-1:0] i_weight_addr,
		input  logic [DATA_WIDTH-1:0]            i_weight,
		input  logic [DATA_WIDTH-1:0]            i_data,
		output logic [NUMBER_OF_OUTPUT_NODE-1:0] o_load_weight_done,
		output logic [DATA_WIDTH-1:0]            o_data,
		output logic                             o_valid
	);

	localparam int RCNT_W = (NUMBER_OF_OUTPUT_NODE > 1) ? $clog2(NUMBER_OF_OUTPUT_NODE) : 1;

	// per-node load strobes from the one-hot address
	logic [NUMBER_OF_OUTPUT_NODE-1:0] weight_strobe;

	// node results
	logic [DATA_WIDTH-1:0]            node_data [NUMBER_OF_OUTPUT_NODE];
	logic [NUMBER_OF_OUTPUT_NODE-1:0] node_valid;

	// capture bank and replay control
	logic [DATA_WIDTH-1:0] bank [NUMBER_OF_OUTPUT_NODE];
	logic                  replay_active;
	logic [RCNT_W-1:0]     replay_cnt;

	assign weight_strobe = {NUMBER_OF_OUTPUT_NODE{i_load_weight_enable}} & i_weight_addr;

	// all nodes see the same serial input stream
	genvar n;
	generate
		for (n = 0; n < NUMBER_OF_OUTPUT_NODE; n++) begin : g_node
			feed_forward_node #(
				.NUMBER_OF_INPUT_NODE (NUMBER_OF_INPUT_NODE),
				.ACT_KIND             (ACT_KIND)
			) u_node (
				.clk                  (clk),
				.rst_n                (rst_n),
				.i_load_weight_enable (weight_strobe[n]),
				.i_load_data_enable   (i_load_data_enable),
				.i_weight             (i_weight),
				.i_data               (i_data),
				.o_load_weight_done   (o_load_weight_done[n]),
				.o_data               (node_data[n]),
				.o_valid              (node_valid[n])
			);
		end
	endgenerate

	// nodes finish together, last node valid marks the capture
	always_ff @(posedge clk) begin
		if (node_valid[NUMBER_OF_OUTPUT_NODE-1]) begin
			for (int k = 0; k < NUMBER_OF_OUTPUT_NODE; k++) begin
				bank[k] <= node_data[k];
			end
		end
	end

	// replay bank one word per cycle, node 0 first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			replay_active <= 1'b0;
			replay_cnt    <= '0;
			o_valid       <= 1'b0;
			o_data        <= '0;
		end else begin
			if (node_valid[NUMBER_OF_OUTPUT_NODE-1]) begin
				replay_active <= 1'b1;
			end
			if (replay_active) begin
				o_valid <= 1'b1;
				o_data  <= bank[replay_cnt];
				// last word ends the replay
				if (replay_cnt == RCNT_W'(NUMBER_OF_OUTPUT_NODE - 1)) begin
					replay_cnt    <= '0;
					replay_active <= 1'b0;
				end else begin
					replay_cnt <= replay_cnt + 1'b1;
				end
			end else begin
				// idle output stays at zero
				o_valid <= 1'b0;
				o_data  <= '0;
			end
		end
	end

	// next sample must wait for the replay to drain
	a_no_valid_in_replay: assert property (
		@(posedge clk) disable iff (!rst_n)
		replay_active |-> (node_valid == '0)
	) else $error("node result arrived during layer replay");

	// at most one node addressed per load word
	a_addr_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_load_weight_enable |-> $onehot0(i_weight_addr)
	) else $error("weight address not one-hot");

endmodule

// ==== logic/mlp_core.sv ====
`timescale 1ns/1ps
module mlp_core
	import mlp_pkg::*;
	#(
		parameter int INPUT_NODES = 2,
		parameter int HIDDEN_NODES = 4,
		parameter int OUTPUT_NODES = 2
	)
	(
		input  logic                                 clk,
		input  logic                                 rst_n,
		input  logic                                 i_load_weight_enable,
		input  logic                                 i_layer_sel,
		input  logic [HIDDEN_NODES-1:0]              i_weight_addr,
		input  logic [DATA_WIDTH-1:0]                i_weight,
		input  logic                                 i_load_data_enable,
		input  logic [DATA_WIDTH-1:0]                i_data,
		output logic [HIDDEN_NODES+OUTPUT_NODES-1:0] o_load_weight_done,
		output logic [DATA_WIDTH-1:0]                o_data,
		output logic                                 o_valid
	);

	// layer select, 0 hidden, 1 output
	logic hid_weight_strobe;
	logic out_weight_strobe;

	logic [HIDDEN_NODES-1:0] hid_done;
	logic [OUTPUT_NODES-1:0] out_done;

	// serial stream between the layers
	logic [DATA_WIDTH-1:0] hid_data;
	logic                  hid_valid;

	assign hid_weight_strobe = i_load_weight_enable & ~i_layer_sel;
	assign out_weight_strobe = i_load_weight_enable & i_layer_sel;

	// hidden layer with leaky relu
	feed_forward_layer #(
		.NUMBER_OF_INPUT_NODE  (INPUT_NODES),
		.NUMBER_OF_OUTPUT_NODE (HIDDEN_NODES),
		.ACT_KIND              (ACT_LEAKY_RELU)
	) u_hidden (
		.clk                  (clk),
		.rst_n                (rst_n),
		.i_load_weight_enable (hid_weight_strobe),
		.i_load_data_enable   (i_load_data_enable),
		.i_weight_addr        (i_weight_addr),
		.i_weight             (i_weight),
		.i_data               (i_data),
		.o_load_weight_done   (hid_done),
		.o_data               (hid_data),
		.o_valid              (hid_valid)
	);

	// output layer, linear, low address bits only
	feed_forward_layer #(
		.NUMBER_OF_INPUT_NODE  (HIDDEN_NODES),
		.NUMBER_OF_OUTPUT_NODE (OUTPUT_NODES),
		.ACT_KIND              (ACT_NONE)
	) u_output (
		.clk                  (clk),
		.rst_n                (rst_n),
		.i_load_weight_enable (out_weight_strobe),
		.i_load_data_enable   (hid_valid),
		.i_weight_addr        (i_weight_addr[OUTPUT_NODES-1:0]),
		.i_weight             (i_weight),
		.i_data               (hid_data),
		.o_load_weight_done   (out_done),
		.o_data               (o_data),
		.o_valid              (o_valid)
	);

	// hidden done bits in the low part
	assign o_load_weight_done = {out_done, hid_done};

endmodule

// ==== tb/mlp_tb_model.svh ====
`ifndef MLP_TB_MODEL_SVH
`define MLP_TB_MODEL_SVH

// one Q7.8 word of the data path
typedef logic signed [DATA_WIDTH-1:0] word_t;

// single neuron, first n entries used
function automatic word_t node_eval(
	input word_t x [HID_N],
	input word_t w [HID_N],
	input word_t b,
	input int    n,
	input bit    leaky
);
	longint acc;
	longint s;
	// bias lifted to product scale
	acc = longint'(b) <<< FRAC_BITS;
	for (int i = 0; i < n; i++) begin
		acc += longint'(x[i]) * longint'(w[i]);
	end
	// arithmetic shift floors
	s = acc >>> FRAC_BITS;
	if (s > longint'(DATA_MAX)) begin
		s = longint'(DATA_MAX);
	end else if (s < longint'(DATA_MIN)) begin
		s = longint'(DATA_MIN);
	end
	// negative side divided by 8, floored
	if (leaky && s < 0) begin
		s = s >>> LEAK_SHIFT;
	end
	return word_t'(s);
endfunction

// full 2-4-2 network, hidden leaky, output linear
function automatic void net_eval(
	input  word_t x0,
	input  word_t x1,
	input  word_t hw [HID_N][IN_N],
	input  word_t hb [HID_N],
	input  word_t ow [OUT_N][HID_N],
	input  word_t ob [OUT_N],
	output word_t y0,
	output word_t y1
);
	word_t xin [HID_N];
	word_t win [HID_N];
	word_t h   [HID_N];
	for (int k = 0; k < HID_N; k++) begin
		xin[k] = '0;
		win[k] = '0;
	end
	xin[0] = x0;
	xin[1] = x1;
	for (int i = 0; i < HID_N; i++) begin
		for (int k = 0; k < IN_N; k++) begin
			win[k] = hw[i][k];
		end
		h[i] = node_eval(xin, win, hb[i], IN_N, 1'b1);
	end
	y0 = node_eval(h, ow[0], ob[0], HID_N, 1'b0);
	y1 = node_eval(h, ow[1], ob[1], HID_N, 1'b0);
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// ==== tb/mlp_tb.sv ====
`timescale 1ns/1ps
module mlp_tb
	import mlp_pkg::*;
	();

	localparam int IN_N  = 2;
	localparam int HID_N = 4;
	localparam int OUT_N = 2;
	localparam int WAIT_LIMIT = 100;

	`include "mlp_tb_model.svh"

	logic                   clk;
	logic                   rst_n;
	logic                   i_load_weight_enable;
	logic                   i_layer_sel;
	logic [HID_N-1:0]       i_weight_addr;
	logic [DATA_WIDTH-1:0]  i_weight;
	logic                   i_load_data_enable;
	logic [DATA_WIDTH-1:0]  i_data;
	logic [HID_N+OUT_N-1:0] o_load_weight_done;
	logic [DATA_WIDTH-1:0]  o_data;
	logic                   o_valid;

	// weight set in use, mirrored by the model
	word_t hw [HID_N][IN_N];
	word_t hb [HID_N];
	word_t ow [OUT_N][HID_N];
	word_t ob [OUT_N];

	// expected output stream, head refreshed on falling edges
	word_t exp_q [$];
	word_t exp_head;
	logic  exp_avail;
	logic  pop_pending;

	// words seen per node, hidden nodes first
	int                     wcount [HID_N+OUT_N];
	logic [HID_N+OUT_N-1:0] exp_done;

	logic [31:0] lfsr_state;
	string       test_name;
	int          err_count;
	int          test_errs;
	int          tests_run;
	int          tests_failed;

	mlp_core #(
		.INPUT_NODES  (IN_N),
		.HIDDEN_NODES (HID_N),
		.OUTPUT_NODES (OUT_N)
	) i_dut (
		.clk                  (clk),
		.rst_n                (rst_n),
		.i_load_weight_enable (i_load_weight_enable),
		.i_layer_sel          (i_layer_sel),
		.i_weight_addr        (i_weight_addr),
		.i_weight             (i_weight),
		.i_load_data_enable   (i_load_data_enable),
		.i_data               (i_data),
		.o_load_weight_done   (o_load_weight_done),
		.o_data               (o_data),
		.o_valid              (o_valid)
	);

	always #2 clk = ~clk;

	// count accepted words per node
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < HID_N + OUT_N; i++) begin
				wcount[i] = 0;
			end
		end else if (i_load_weight_enable) begin
			for (int i = 0; i < HID_N; i++) begin
				if (!i_layer_sel && i_weight_addr[i]) begin
					wcount[i]++;
				end
			end
			for (int j = 0; j < OUT_N; j++) begin
				if (i_layer_sel && i_weight_addr[j]) begin
					wcount[HID_N+j]++;
				end
			end
		end
	end

	// expectations settle between edges
	always @(negedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			pop_pending = 1'b0;
		end else if (pop_pending && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
		end
		exp_avail   = (exp_q.size() != 0);
		exp_head    = exp_avail ? exp_q[0] : '0;
		pop_pending = rst_n && o_valid;
		// done once weights and bias are in
		for (int i = 0; i < HID_N + OUT_N; i++) begin
			exp_done[i] = (wcount[i] >= ((i < HID_N) ? IN_N + 1 : HID_N + 1));
		end
	end

	a_out_expected: assert property (
		@(posedge clk) disable iff (!rst_n)
		o_valid |-> exp_avail
	) else begin
		err_count++;
		$display("test %s: output valid with no value expected", test_name);
	end

	a_out_value: assert property (
		@(posedge clk) disable iff (!rst_n)
		(o_valid && exp_avail) |-> (o_data == exp_head)
	) else begin
		err_count++;
		$display("mismatch in test %s: expected %0d, actual %0d",
			test_name, exp_head, $signed($sampled(o_data)));
	end

	a_done_bits: assert property (
		@(posedge clk) disable iff (!rst_n)
		o_load_weight_done == exp_done
	) else begin
		err_count++;
		$display("mismatch in test %s: expected done %b, actual %b",
			test_name, exp_done, $sampled(o_load_weight_done));
	end

	a_idle_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		!o_valid |-> (o_data == '0)
	) else begin
		err_count++;
		$display("test %s: output data not zero while idle", test_name);
	end

	// reset must hold valid and done low
	a_reset_clear: assert property (
		@(posedge clk)
		!rst_n |-> (!o_valid && o_load_weight_done == '0)
	) else begin
		err_count++;
		$display("test %s: reset did not clear valid and done", test_name);
	end

	// n lfsr bits, sign extended
	function automatic word_t rand_signed(input int nbits);
		longint v;
		v = 0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | longint'(lfsr_state[0]);
		end
		if (v >= (longint'(1) << (nbits - 1))) begin
			v -= longint'(1) << nbits;
		end
		return word_t'(v);
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic release_inputs();
		@(negedge clk);
		i_load_weight_enable = 1'b0;
		i_layer_sel          = 1'b0;
		i_weight_addr        = '0;
		i_weight             = '0;
		i_load_data_enable   = 1'b0;
		i_data               = '0;
	endtask

	// low for two cycles, inputs idle
	task automatic apply_reset();
		release_inputs();
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic load_word(input logic sel, input int node, input word_t w);
		@(negedge clk);
		i_load_weight_enable = 1'b1;
		i_layer_sel          = sel;
		i_weight_addr        = '0;
		i_weight_addr[node]  = 1'b1;
		i_weight             = w;
	endtask

	// weights in input order, bias last
	task automatic load_weights();
		for (int i = 0; i < HID_N; i++) begin
			for (int k = 0; k < IN_N; k++) begin
				load_word(1'b0, i, hw[i][k]);
			end
			load_word(1'b0, i, hb[i]);
		end
		for (int j = 0; j < OUT_N; j++) begin
			for (int k = 0; k < HID_N; k++) begin
				load_word(1'b1, j, ow[j][k]);
			end
			load_word(1'b1, j, ob[j]);
		end
		release_inputs();
	endtask

	task automatic fill_random_weights();
		for (int i = 0; i < HID_N; i++) begin
			for (int k = 0; k < IN_N; k++) begin
				hw[i][k] = rand_signed(12);
			end
			hb[i] = rand_signed(12);
		end
		for (int j = 0; j < OUT_N; j++) begin
			for (int k = 0; k < HID_N; k++) begin
				ow[j][k] = rand_signed(10);
			end
			ob[j] = rand_signed(12);
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			abort_run($sformatf("timeout in test %s: %0d outputs never arrived",
				test_name, exp_q.size()));
		end
	endtask

	task automatic wait_first_output();
		int cycles;
		cycles = 0;
		while (!o_valid && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!o_valid) begin
			abort_run($sformatf("timeout in test %s: output valid never rose", test_name));
		end
	endtask

	// model result queued, then two input cycles
	task automatic drive_sample(input word_t x0, input word_t x1);
		word_t y0;
		word_t y1;
		net_eval(x0, x1, hw, hb, ow, ob, y0, y1);
		exp_q.push_back(y0);
		exp_q.push_back(y1);
		@(negedge clk);
		i_load_data_enable = 1'b1;
		i_data             = x0;
		@(negedge clk);
		i_data = x1;
		@(negedge clk);
		i_load_data_enable = 1'b0;
		i_data             = '0;
	endtask

	task automatic send_sample(input word_t x0, input word_t x1);
		drive_sample(x0, x1);
		wait_drained();
		// gap before the next sample
		repeat (2 * HID_N + 4) @(negedge clk);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = err_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_count != test_errs) begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, err_count - test_errs);
		end else begin
			$display("test %s passed", test_name);
		end
	endtask

	initial begin
		clk                  = 1'b0;
		rst_n                = 1'b0;
		i_load_weight_enable = 1'b0;
		i_layer_sel          = 1'b0;
		i_weight_addr        = '0;
		i_weight             = '0;
		i_load_data_enable   = 1'b0;
		i_data               = '0;
		lfsr_state           = 32'h3c0bd912;
		err_count            = 0;
		tests_run            = 0;
		tests_failed         = 0;
		start_test("weight_load");
		apply_reset();
		hw = '{'{16'sh0100, 16'sh0080}, '{16'shff00, 16'sh0200},
			'{16'sh0040, 16'shffc0}, '{16'sh0180, 16'sh0100}};
		hb = '{16'sh0010, 16'sh0000, 16'shff80, 16'sh0020};
		ow = '{'{16'sh0100, 16'sh0080, 16'shff80, 16'sh0040},
			'{16'shff00, 16'sh0100, 16'sh0200, 16'shffc0}};
		ob = '{16'sh0008, 16'shfff0};
		load_weights();
		// extra words land after done and must be dropped
		load_word(1'b0, 0, 16'sh7fff);
		load_word(1'b0, 0, 16'sh1234);
		load_word(1'b1, 1, 16'sh7fff);
		release_inputs();
		repeat (2) @(negedge clk);
		end_test();
		start_test("known_sample");
		send_sample(16'sh0100, 16'sh0080);
		send_sample(16'shff40, 16'sh0200);
		end_test();
		// hidden sums driven negative
		start_test("leaky_relu");
		apply_reset();
		hw = '{'{16'shff00, 16'shff80}, '{16'shfe00, 16'sh0040},
			'{16'sh0100, 16'shfd00}, '{16'shff40, 16'shffc0}};
		hb = '{16'sh0000, 16'shffc0, 16'sh0010, 16'shff00};
		ow = '{'{16'sh0100, 16'sh0100, 16'sh0100, 16'sh0100},
			'{16'shff00, 16'sh0080, 16'shff00, 16'sh0040}};
		ob = '{16'sh0000, 16'shff00};
		load_weights();
		send_sample(16'sh0180, 16'sh00c0);
		send_sample(16'sh0240, 16'sh0300);
		end_test();
		start_test("saturation");
		apply_reset();
		hw = '{'{16'sh7fff, 16'sh7fff}, '{16'sh8000, 16'sh8000},
			'{16'sh7fff, 16'sh8000}, '{16'sh0100, 16'sh0100}};
		hb = '{16'sh7fff, 16'sh8000, 16'sh0000, 16'sh0000};
		ow = '{'{16'sh7fff, 16'sh7fff, 16'sh7fff, 16'sh7fff},
			'{16'sh8000, 16'sh8000, 16'sh8000, 16'sh8000}};
		ob = '{16'sh7fff, 16'sh8000};
		load_weights();
		send_sample(16'sh7fff, 16'sh7fff);
		send_sample(16'sh8000, 16'sh7fff);
		end_test();
		start_test("random");
		apply_reset();
		fill_random_weights();
		load_weights();
		for (int s = 0; s < 20; s++) begin
			send_sample(rand_signed(14), rand_signed(14));
		end
		end_test();
		start_test("reset");
		// first reset lands while the output layer replays
		drive_sample(rand_signed(14), rand_signed(14));
		wait_first_output();
		apply_reset();
		load_weights();
		// second reset lands after the first input of a sample
		@(negedge clk);
		i_load_data_enable = 1'b1;
		i_data             = rand_signed(14);
		apply_reset();
		load_weights();
		send_sample(rand_signed(14), rand_signed(14));
		end_test();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+tb
logic/mlp_pkg.sv
logic/feed_forward_node.sv
logic/feed_forward_layer.sv
logic/mlp_core.sv
tb/mlp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the MLP testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module mlp_tb -o mlp_sim

# the simulation output decides pass or fail
out=$(./obj_dir/mlp_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi
